/* src/rng_pkg.sv */
// ------------------------------
// shared defaults for the entropy harvester
// credit count is 4 bits wide, so CREDITS may not exceed 15
// ------------------------------
`default_nettype none

package rng_pkg;

	// word width in bits
	localparam int DEFAULT_WIDTH = 16;

	// lfsr seed after reset
	localparam logic [15:0] DEFAULT_INIT = 16'hace1;

	// lfsr tap mask, a set bit means the state bit joins the parity
	localparam logic [15:0] DEFAULT_FEEDBACK = 16'h002d;

	// credits the consumer holds right after reset
	localparam int DEFAULT_CREDITS = 2;

	// width of the credit count
	localparam int CREDIT_BITS = 4;

	// harvest sequencing
	typedef enum logic [1:0] {
		COLLECT,
		WAIT_CREDIT,
		EMIT
	} harvest_state_t;

endpackage

`default_nettype wire

/* src/von_neumann_debias.sv */
// ------------------------------
// von neumann debiaser, one output bit per unequal pair
// raw bits cannot be stalled, pairing runs on regardless
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module von_neumann_debias (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic raw_bit,
	input  wire logic raw_valid,
	output logic      deb_bit,
	output logic      deb_valid
);

	// first bit of the pair in progress
	logic first_bit;
	// set once the first bit of a pair is held
	logic have_first;

	always_ff @(posedge clk) begin
		if (reset) begin
			have_first <= 1'b0;
			deb_valid  <= 1'b0;
		end else begin
			// strobe lasts one cycle unless renewed below
			deb_valid <= 1'b0;
			if (raw_valid) begin
				have_first <= !have_first;
				// 01 gives 0, 10 gives 1, equal pairs are dropped
				if (have_first && (first_bit != raw_bit))
					deb_valid <= 1'b1;
			end
		end
	end

	// first bit of the pair and the bit on offer
	always_ff @(posedge clk) begin
		if (raw_valid && !have_first)
			first_bit <= raw_bit;
		if (raw_valid && have_first)
			deb_bit <= first_bit;
	end

	// a pair needs two raw bits, so output strobes are never back to back
	a_deb_no_repeat: assert property (@(posedge clk) disable iff (reset)
		deb_valid |=> !deb_valid);

endmodule

`default_nettype wire

/* src/entropy_lfsr.sv */
// ------------------------------
// fibonacci style lfsr with an entropy bit xored into feedback
// state is kept across words, only reset reseeds it
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module entropy_lfsr
	import rng_pkg::*;
#(
	parameter int               WIDTH      = DEFAULT_WIDTH,
	parameter logic [WIDTH-1:0] INIT_VALUE = DEFAULT_INIT,
	parameter logic [WIDTH-1:0] FEEDBACK   = DEFAULT_FEEDBACK
) (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             absorb,
	input  wire logic             deb_bit,
	output logic      [WIDTH-1:0] state
);

	// parity over the tapped bits
	logic tap_parity;
	// bit that enters at the bottom
	logic new_bit;

	assign tap_parity = ^(state & FEEDBACK);
	assign new_bit    = tap_parity ^ deb_bit;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= INIT_VALUE;
		end else if (absorb) begin
			// shift up, mixed bit lands in bit 0
			state <= {state[WIDTH-2:0], new_bit};
		end
	end

endmodule

`default_nettype wire

/* src/bit_counter.sv */
// ------------------------------
// counts absorbed bits, word_full is a flop
// stays full until word_take clears it
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module bit_counter
	import rng_pkg::*;
#(
	parameter int WIDTH = DEFAULT_WIDTH
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic absorb,
	input  wire logic word_take,
	output logic      word_full
);

	// one extra bit so WIDTH itself is representable
	localparam int CNT_BITS = $clog2(WIDTH) + 1;

	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] count_next;

	always_comb begin
		count_next = count;
		if (word_take)
			count_next = '0;
		else if (absorb)
			count_next = count + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count     <= '0;
			word_full <= 1'b0;
		end else begin
			count     <= count_next;
			// full from the edge that takes the last bit
			word_full <= (count_next == CNT_BITS'(WIDTH));
		end
	end

	// the fsm must stop absorbing once the word is complete
	a_no_absorb_when_full: assert property (@(posedge clk) disable iff (reset)
		word_full |-> !absorb);

endmodule

`default_nettype wire

/* src/credit_counter.sv */
// ------------------------------
// consumer credit pool, starts at CREDITS
// a spend and a return in one cycle cancel out
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module credit_counter
	import rng_pkg::*;
#(
	parameter int CREDITS = DEFAULT_CREDITS
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic spend,
	input  wire logic credit_return,
	output logic      credit_avail
);

	// credits the consumer still holds
	logic [CREDIT_BITS-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= CREDIT_BITS'(CREDITS);
		end else begin
			case ({spend, credit_return})
				2'b10:   count <= count - 1'b1;
				2'b01:   count <= count + 1'b1;
				// both or neither leave the pool alone
				default: count <= count;
			endcase
		end
	end

	assign credit_avail = (count != '0);

	// fsm only issues a word when a credit is held
	a_no_spend_at_zero: assert property (@(posedge clk) disable iff (reset)
		spend |-> (count != '0));

	// consumer never returns more than it was given
	a_no_return_at_full: assert property (@(posedge clk) disable iff (reset)
		(credit_return && !spend) |-> (count != CREDIT_BITS'(CREDITS)));

	// pool bound over the whole run
	a_count_bounded: assert property (@(posedge clk) disable iff (reset)
		count <= CREDIT_BITS'(CREDITS));

endmodule

`default_nettype wire

/* src/harvest_fsm.sv */
// ------------------------------
// sequences collect, credit wait and word issue
// deb bits arriving outside COLLECT are lost on purpose
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module harvest_fsm
	import rng_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic deb_valid,
	input  wire logic word_full,
	input  wire logic credit_avail,
	input  wire logic credit_return,
	output logic      absorb,
	output logic      word_take,
	output logic      spend,
	output logic      word_valid
);

	harvest_state_t state;
	harvest_state_t state_next;

	always_ff @(posedge clk) begin
		if (reset)
			state <= COLLECT;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			COLLECT: begin
				// word complete, issue now or park until credit shows up
				if (word_full)
					state_next = credit_avail ? EMIT : WAIT_CREDIT;
			end
			WAIT_CREDIT: begin
				// a return in this very cycle is enough to go
				if (credit_avail || credit_return)
					state_next = EMIT;
			end
			EMIT: begin
				state_next = COLLECT;
			end
			default: begin
				state_next = COLLECT;
			end
		endcase
	end

	// only take entropy while building a word
	assign absorb = deb_valid && (state == COLLECT);

	// one cycle issue, counter cleared and credit spent together
	assign word_valid = (state == EMIT);
	assign spend      = (state == EMIT);
	assign word_take  = (state == EMIT);

	// credit pool must hold a credit whenever a word goes out
	a_valid_needs_credit: assert property (@(posedge clk) disable iff (reset)
		word_valid |-> credit_avail);

endmodule

`default_nettype wire

/* src/rng_top.sv */
// ------------------------------
// random word harvester, raw entropy bit enters as a port
// word is stable while word_valid is high
// CREDITS must fit the 4 bit credit count
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module rng_top
	import rng_pkg::*;
#(
	parameter int               WIDTH      = DEFAULT_WIDTH,
	parameter logic [WIDTH-1:0] INIT_VALUE = DEFAULT_INIT,
	parameter logic [WIDTH-1:0] FEEDBACK   = DEFAULT_FEEDBACK,
	parameter int               CREDITS    = DEFAULT_CREDITS
) (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             raw_bit,
	input  wire logic             raw_valid,
	input  wire logic             credit_return,
	output logic      [WIDTH-1:0] word,
	output logic                  word_valid
);

	// debiased stream
	logic deb_bit;
	logic deb_valid;
	// fsm controls
	logic absorb;
	logic word_take;
	logic spend;
	// status back to the fsm
	logic word_full;
	logic credit_avail;

	von_neumann_debias u_debias (
		.clk       (clk),
		.reset     (reset),
		.raw_bit   (raw_bit),
		.raw_valid (raw_valid),
		.deb_bit   (deb_bit),
		.deb_valid (deb_valid)
	);

	// lfsr state is the word itself
	entropy_lfsr #(
		.WIDTH      (WIDTH),
		.INIT_VALUE (INIT_VALUE),
		.FEEDBACK   (FEEDBACK)
	) u_lfsr (
		.clk     (clk),
		.reset   (reset),
		.absorb  (absorb),
		.deb_bit (deb_bit),
		.state   (word)
	);

	bit_counter #(
		.WIDTH (WIDTH)
	) u_bit_counter (
		.clk       (clk),
		.reset     (reset),
		.absorb    (absorb),
		.word_take (word_take),
		.word_full (word_full)
	);

	credit_counter #(
		.CREDITS (CREDITS)
	) u_credit_counter (
		.clk           (clk),
		.reset         (reset),
		.spend         (spend),
		.credit_return (credit_return),
		.credit_avail  (credit_avail)
	);

	harvest_fsm u_fsm (
		.clk           (clk),
		.reset         (reset),
		.deb_valid     (deb_valid),
		.word_full     (word_full),
		.credit_avail  (credit_avail),
		.credit_return (credit_return),
		.absorb        (absorb),
		.word_take     (word_take),
		.spend         (spend),
		.word_valid    (word_valid)
	);

endmodule

`default_nettype wire

/* tests/rng_tb.sv */
// ------------------------------
// testbench for rng_top, run from the project root
// vectors come from tests/rng_vectors.txt
// expects every word to use fresh pairs, no discards
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

module rng_tb
	import rng_pkg::*;
();

	logic                     clk;
	logic                     reset;
	logic                     raw_bit;
	logic                     raw_valid;
	logic                     credit_return;
	logic [DEFAULT_WIDTH-1:0] word;
	logic                     word_valid;

	// commands loaded from the vector file, one argument each
	logic [7:0]               cmd_q[$];
	int                       arg_q[$];
	logic [DEFAULT_WIDTH-1:0] expect_q[$];

	int expected_total = 0;
	int cycle_limit    = 200;
	int cycles         = 0;
	// consumer side bookkeeping
	int words_seen     = 0;
	int returns_sent   = 0;
	int useful_pairs   = 0;
	int word_errors    = 0;
	int flag_errors    = 0;
	int other_errors   = 0;
	int extra_words    = 0;
	// own copy of the pairing, counts unequal pairs fed
	logic have_first;
	logic first_bit;

	rng_top #(
		.WIDTH      (DEFAULT_WIDTH),
		.INIT_VALUE (DEFAULT_INIT),
		.FEEDBACK   (DEFAULT_FEEDBACK),
		.CREDITS    (DEFAULT_CREDITS)
	) u_rng_top (
		.clk           (clk),
		.reset         (reset),
		.raw_bit       (raw_bit),
		.raw_valid     (raw_valid),
		.credit_return (credit_return),
		.word          (word),
		.word_valid    (word_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_word(input string name, input logic [DEFAULT_WIDTH-1:0] actual,
			input logic [DEFAULT_WIDTH-1:0] expected);
		if (actual !== expected) begin
			word_errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			flag_errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, actual, expected);
		end
	endtask

	// reads every command up front so the run length is known
	task automatic load_vectors();
		int                       fd;
		int                       n;
		int                       val;
		int                       idle_total;
		logic [7:0]               tok;
		logic [8*128-1:0]         rest;
		logic [DEFAULT_WIDTH-1:0] hex_val;
		idle_total = 0;
		fd = $fopen("tests/rng_vectors.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open the vector file tests/rng_vectors.txt");
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1)
				break;
			if (tok == "#") begin
				// comment runs to end of line
				n = $fgets(rest, fd);
			end else if (tok == "R" || tok == "I") begin
				n = $fscanf(fd, "%d", val);
				cmd_q.push_back(tok);
				arg_q.push_back(val);
				if (tok == "I")
					idle_total += val;
			end else if (tok == "C") begin
				cmd_q.push_back(tok);
				arg_q.push_back(0);
			end else if (tok == "E") begin
				n = $fscanf(fd, "%h", hex_val);
				expect_q.push_back(hex_val);
			end else begin
				other_errors++;
				$display("unknown command %s in the vector file", tok);
			end
		end
		$fclose(fd);
		expected_total = expect_q.size();
		cycle_limit    = 4 * cmd_q.size() + idle_total + 200;
	endtask

	// one clock of stimulus, applied on the falling edge
	task automatic drive_cycle(input logic valid, input logic bit_val, input logic ret);
		@(negedge clk);
		raw_valid     = valid;
		raw_bit       = bit_val;
		credit_return = ret;
	endtask

	task automatic feed_raw(input logic b);
		drive_cycle(1'b1, b, 1'b0);
		if (!have_first) begin
			first_bit  = b;
			have_first = 1'b1;
		end else begin
			have_first = 1'b0;
			// only unequal pairs carry a bit
			if (first_bit != b)
				useful_pairs++;
		end
	endtask

	initial begin
		int i;
		raw_bit       = 1'b0;
		raw_valid     = 1'b0;
		credit_return = 1'b0;
		reset         = 1'b1;
		have_first    = 1'b0;
		first_bit     = 1'b0;
		load_vectors();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (i = 0; i < cmd_q.size(); i++) begin
			case (cmd_q[i])
				"R": feed_raw(arg_q[i] != 0);
				"I": repeat (arg_q[i]) drive_cycle(1'b0, 1'b0, 1'b0);
				"C": begin
					drive_cycle(1'b0, 1'b0, 1'b1);
					returns_sent++;
				end
				default: ;
			endcase
		end
		drive_cycle(1'b0, 1'b0, 1'b0);
		// last word may still be on its way
		while (words_seen < expected_total)
			@(negedge clk);
		// room for a stray word to show up
		repeat (20) @(negedge clk);
		if (words_seen != expected_total) begin
			other_errors++;
			$display("saw %0d words but the vectors expect %0d", words_seen, expected_total);
		end
		$display("words %0d of %0d, word errors %0d, flag errors %0d, other errors %0d",
			words_seen, expected_total, word_errors, flag_errors,
			other_errors + extra_words);
		if (word_errors + flag_errors + other_errors + extra_words == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// word monitor, values read here are the ones before this edge
	always @(posedge clk) begin
		if (!reset && word_valid) begin
			// consumer must have held a credit for this word
			check_flag("credit_avail", (DEFAULT_CREDITS - words_seen + returns_sent) > 0, 1'b1);
			// WIDTH fresh pairs per word, state carries over
			check_flag("useful_pairs_ready",
				useful_pairs >= (words_seen + 1) * DEFAULT_WIDTH, 1'b1);
			if (words_seen < expected_total) begin
				check_word("word", word, expect_q[words_seen]);
			end else begin
				extra_words++;
				$display("word %h arrived after all expected words were seen", word);
			end
			words_seen++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the vectors never finished", cycles);
			$display("Errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tests/rng_vectors.txt */
# R <bit> one raw cycle, I <n> n idle cycles, C one credit return pulse
# E <hex> next expected word; pairs 0 1 give 0, 1 0 give 1, equal pairs give nothing
I 8
R 0 R 1 R 0 R 1 R 1 R 1 R 0 R 1 R 1 R 0 R 0 R 1 R 0 R 1 R 1 R 0 R 0 R 1
R 1 R 0 R 1 R 0 R 0 R 1 R 0 R 0 R 0 R 1 R 1 R 0 R 0 R 1 R 0 R 1 R 0 R 1
E 3c5a
I 4
R 0 R 1 R 1 R 0 R 0 R 1 R 0 R 1 R 0 R 1 R 0 R 1 R 0 R 1 R 1 R 0
R 1 R 1 R 0 R 1 R 1 R 0 R 0 R 1 R 0 R 1 R 0 R 1 R 1 R 0 R 1 R 0 R 1 R 0
E 9e17
I 4
# credits are used up here, this word waits for a return
R 0 R 1 R 0 R 1 R 0 R 1 R 1 R 0 R 1 R 1 R 1 R 0 R 0 R 1 R 0 R 1 R 0 R 1
R 0 R 1 R 1 R 0 R 0 R 1 R 1 R 0 R 0 R 1 R 0 R 1 R 1 R 0 R 1 R 0
E 6bd2
I 40
C
I 4
C
C
I 2
R 1 R 0 R 0 R 1 R 1 R 0 R 1 R 0 R 0 R 1 R 0 R 1 R 1 R 0 R 0 R 1
R 1 R 0 R 1 R 0 R 0 R 0 R 0 R 1 R 0 R 1 R 1 R 0 R 0 R 1 R 1 R 0 R 0 R 1
E f00d
I 4
R 1 R 0 R 1 R 0 R 1 R 0 R 1 R 0 R 1 R 1 R 1 R 0 R 1 R 0 R 0 R 1 R 1 R 0
R 1 R 0 R 0 R 1 R 0 R 1 R 1 R 0 R 0 R 1 R 1 R 0 R 0 R 1 R 1 R 0
E 2b47
I 4

/* all.f */
src/rng_pkg.sv
src/von_neumann_debias.sv
src/entropy_lfsr.sv
src/bit_counter.sv
src/credit_counter.sv
src/harvest_fsm.sv
src/rng_top.sv
tests/rng_tb.sv

/* Makefile */
# Verilator flow for the entropy harvester, run from the project root

VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
TOP        = rng_tb
FILELIST   = all.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
